//--- hdl/mipsMem_defines.svh
`ifndef MIPS_MEM_DEFINES_SVH
`define MIPS_MEM_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data, address and instruction address
`define DATA_W      32

// Register number, 32 registers
`define REG_ADDR_W  5

//////////////////////////////////////////////////
// Data memory geometry
//////////////////////////////////////////////////

// Depth in words, indexed by address bits 9:2
`define MEM_WORDS   256
`define MEM_ADDR_W  8

// Destination forced by jump-and-link
`define LINK_REG    31

`endif

//--- hdl/mipsMemPkg.sv
`include "mipsMem_defines.svh"

package mipsMemPkg;

    //////////////////////////////////////////////////
    // Datapath values
    //////////////////////////////////////////////////

    // Data, address, instruction address
    typedef logic [`DATA_W-1:0] word_t;

    // Register file index
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    //////////////////////////////////////////////////
    // Control fields from execute
    //////////////////////////////////////////////////

    // Write-back control
    // Bit 0 regWrite
    // Bit 1 memToReg
    // Bits 3:2 access size
    // Bit 4 loadUnsigned
    typedef logic [4:0] wbCtrl_t;

    // Memory control
    // Bit 0 memWrite
    // Bit 1 memRead
    typedef logic [1:0] memCtrl_t;

    // Access size
    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0] accSize_t;

endpackage

//--- hdl/dataMemory.sv
`timescale 1ns/1ps

`include "mipsMem_defines.svh"

module dataMemory
    import mipsMemPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  memCtrl_t memCtrl,
    input  logic     debugOn,
    input  logic     stopDebug,
    input  word_t    address,
    input  word_t    writeData,
    input  accSize_t accSize,
    input  logic     loadUnsigned,
    input  word_t    debugAddr,
    output word_t    readData,
    output word_t    memDebug
);

    // Word storage, little-endian byte lanes
    word_t mem [`MEM_WORDS];

    logic [`MEM_ADDR_W-1:0] wordIdx;
    logic [`MEM_ADDR_W-1:0] debugIdx;
    logic [1:0]             byteOff;
    logic [3:0]             byteEn;
    word_t                  laneData;
    logic                   writeEn;
    word_t                  rawWord;
    logic [7:0]             loadByte;
    logic [15:0]            loadHalf;
    word_t                  loadExt;

    // Word index from bits 9:2, low bits pick the lane
    assign wordIdx  = address[`MEM_ADDR_W+1:2];
    assign byteOff  = address[1:0];
    assign debugIdx = debugAddr[`MEM_ADDR_W+1:2];

    // Debug mode and freeze both make the memory read-only
    assign writeEn = memCtrl[0] & ~debugOn & ~stopDebug;

    //////////////////////////////////////////////////
    // Store path
    //////////////////////////////////////////////////

    // Lane enables and replicated store data per size
    always_comb
    begin
        case (accSize)
            2'd0:
            begin
                byteEn   = 4'b0001 << byteOff;
                laneData = {4{writeData[7:0]}};
            end
            2'd1:
            begin
                // Bit 1 picks the upper or lower half
                byteEn   = byteOff[1] ? 4'b1100 : 4'b0011;
                laneData = {2{writeData[15:0]}};
            end
            default:
            begin
                byteEn   = 4'b1111;
                laneData = writeData;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `MEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            // Only enabled lanes change
            for (int b = 0; b < 4; b++)
            begin
                if (byteEn[b])
                begin
                    mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Load path
    //////////////////////////////////////////////////

    assign rawWord  = mem[wordIdx];
    assign loadByte = rawWord[8*byteOff +: 8];
    assign loadHalf = byteOff[1] ? rawWord[31:16] : rawWord[15:0];

    // Sign or zero extension by loadUnsigned
    always_comb
    begin
        case (accSize)
            2'd0:    loadExt = {{24{~loadUnsigned & loadByte[7]}}, loadByte};
            2'd1:    loadExt = {{16{~loadUnsigned & loadHalf[15]}}, loadHalf};
            default: loadExt = rawWord;
        endcase
    end

    // Zero when no read is requested
    assign readData = memCtrl[1] ? loadExt : '0;

    // Separate debug port, whole word
    assign memDebug = mem[debugIdx];

endmodule

//--- hdl/memoryAccess.sv
`timescale 1ns/1ps

`include "mipsMem_defines.svh"

module memoryAccess
    import mipsMemPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  wbCtrl_t  wbCtrlIn,
    input  memCtrl_t memCtrlIn,
    input  logic     jumpLink,
    input  word_t    instrAddr,
    input  word_t    aluResult,
    input  word_t    regB,
    input  regAddr_t destReg,
    input  logic     debugOn,
    input  word_t    debugAddr,
    input  logic     stopDebug,
    output wbCtrl_t  wbCtrl,
    output logic     wbValid,
    output word_t    aluResultWb,
    output word_t    memDataWb,
    output regAddr_t destRegWb,
    output word_t    memDebug
);

    // Extended load data from the memory
    word_t    loadData;

    // Next stage register contents
    wbCtrl_t  ctrlNext;
    regAddr_t destNext;
    word_t    memDataNext;

    //////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////

    // ALU result is the address, regB the store data
    dataMemory dm0 (
        .clk          (clk),
        .rst          (rst),
        .memCtrl      (memCtrlIn),
        .debugOn      (debugOn),
        .stopDebug    (stopDebug),
        .address      (aluResult),
        .writeData    (regB),
        .accSize      (accSize_t'(wbCtrlIn[3:2])),
        .loadUnsigned (wbCtrlIn[4]),
        .debugAddr    (debugAddr),
        .readData     (loadData),
        .memDebug     (memDebug)
    );

    //////////////////////////////////////////////////
    // Jump-and-link override
    //////////////////////////////////////////////////

    always_comb
    begin
        ctrlNext    = wbCtrlIn;
        destNext    = destReg;
        memDataNext = loadData;
        if (jumpLink)
        begin
            // Return address goes through the memory data path
            ctrlNext[1] = 1'b1;
            destNext    = regAddr_t'(`LINK_REG);
            memDataNext = instrAddr;
        end
    end

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbCtrl      <= '0;
            wbValid     <= 1'b0;
            aluResultWb <= '0;
            memDataWb   <= '0;
            destRegWb   <= '0;
        end
        else if (stopDebug)
        begin
            // Hold contents, bubble toward write back
            wbValid <= 1'b0;
        end
        else
        begin
            wbCtrl      <= ctrlNext;
            wbValid     <= 1'b1;
            aluResultWb <= aluResult;
            memDataWb   <= memDataNext;
            destRegWb   <= destNext;
        end
    end

endmodule

//--- hdl/writeBackRegFile.sv
`timescale 1ns/1ps

`include "mipsMem_defines.svh"

module writeBackRegFile
    import mipsMemPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  wbCtrl_t  wbCtrl,
    input  logic     wbValid,
    input  word_t    aluResultWb,
    input  word_t    memDataWb,
    input  regAddr_t destRegWb,
    input  regAddr_t regReadAddr,
    output word_t    regReadData
);

    localparam int NumRegs = 1 << `REG_ADDR_W;

    // General purpose registers
    word_t regs [NumRegs];

    word_t writeData;
    logic  writeEn;

    //////////////////////////////////////////////////
    // Write-back selection
    //////////////////////////////////////////////////

    // memToReg picks memory data over the ALU result
    assign writeData = wbCtrl[1] ? memDataWb : aluResultWb;

    // Bubble or register 0 blocks the write
    assign writeEn = wbCtrl[0] & wbValid & (destRegWb != '0);

    //////////////////////////////////////////////////
    // Register array
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            regs[destRegWb] <= writeData;
        end
    end

    // Observation port, register 0 hardwired to zero
    always_comb
    begin
        if (regReadAddr == '0)
        begin
            regReadData = '0;
        end
        else
        begin
            regReadData = regs[regReadAddr];
        end
    end

endmodule

//--- hdl/memWbPipe.sv
`timescale 1ns/1ps

`include "mipsMem_defines.svh"

module memWbPipe
    import mipsMemPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  wbCtrl_t  wbCtrlIn,
    input  memCtrl_t memCtrlIn,
    input  logic     jumpLink,
    input  word_t    instrAddr,
    input  word_t    aluResult,
    input  word_t    regB,
    input  regAddr_t destReg,
    input  logic     debugOn,
    input  word_t    debugAddr,
    input  logic     stopDebug,
    input  regAddr_t regReadAddr,
    output word_t    memDebug,
    output word_t    regReadData
);

    //////////////////////////////////////////////////
    // Memory-access to write-back wires
    //////////////////////////////////////////////////

    wbCtrl_t  wbCtrl;
    logic     wbValid;
    word_t    aluResultWb;
    word_t    memDataWb;
    regAddr_t destRegWb;

    // Memory stage with its stage register
    memoryAccess ma0 (
        .clk         (clk),
        .rst         (rst),
        .wbCtrlIn    (wbCtrlIn),
        .memCtrlIn   (memCtrlIn),
        .jumpLink    (jumpLink),
        .instrAddr   (instrAddr),
        .aluResult   (aluResult),
        .regB        (regB),
        .destReg     (destReg),
        .debugOn     (debugOn),
        .debugAddr   (debugAddr),
        .stopDebug   (stopDebug),
        .wbCtrl      (wbCtrl),
        .wbValid     (wbValid),
        .aluResultWb (aluResultWb),
        .memDataWb   (memDataWb),
        .destRegWb   (destRegWb),
        .memDebug    (memDebug)
    );

    // Write back, freeze arrives only as wbValid
    writeBackRegFile wb0 (
        .clk         (clk),
        .rst         (rst),
        .wbCtrl      (wbCtrl),
        .wbValid     (wbValid),
        .aluResultWb (aluResultWb),
        .memDataWb   (memDataWb),
        .destRegWb   (destRegWb),
        .regReadAddr (regReadAddr),
        .regReadData (regReadData)
    );

endmodule

//--- verif/memWbPipe_props.sv
`timescale 1ns/1ps

`include "mipsMem_defines.svh"

module memWbPipe_props
    import mipsMemPkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   stopDebug,
    input logic                   debugOn,
    input logic                   jumpLink,
    input logic                   wbValid,
    input logic [`MEM_ADDR_W-1:0] memIdx,
    input word_t                  memArr [`MEM_WORDS],
    input regAddr_t               destRegWb
);

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    // Reset leaves a bubble toward write back
    resetBubble: assert property (@(posedge clk) rst |=> !wbValid)
        else $error("wbValid high in the cycle after reset");

    // Link destination whenever a jump-and-link is latched
    linkDest: assert property (@(posedge clk) disable iff (rst)
        (jumpLink && !stopDebug) |=> (destRegWb == regAddr_t'(`LINK_REG)))
        else $error("jump-and-link latched a destination other than the link register");

    //////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////

    // Freeze and debug mode keep the addressed word unchanged across the edge
    readOnly: assert property (@(posedge clk) disable iff (rst)
        (stopDebug || debugOn) |=> (memArr[$past(memIdx)] == $past(memArr[memIdx])))
        else $error("memory word changed during freeze or debug mode");

endmodule

// Attached to every memory-access stage
bind memoryAccess memWbPipe_props props0 (
    .clk        (clk),
    .rst        (rst),
    .stopDebug  (stopDebug),
    .debugOn    (debugOn),
    .jumpLink   (jumpLink),
    .wbValid    (wbValid),
    .memIdx     (dm0.wordIdx),
    .memArr     (dm0.mem),
    .destRegWb  (destRegWb)
);

//--- verif/memWbPipe_tb.sv
`timescale 1ns/1ps

`include "mipsMem_defines.svh"

module memWbPipe_tb
    import mipsMemPkg::*;
();

    // Check kinds per row
    localparam logic [1:0] ChkNone = 2'd0;
    localparam logic [1:0] ChkReg  = 2'd1;
    localparam logic [1:0] ChkMem  = 2'd2;

    // Memory control shorthands
    localparam memCtrl_t MemNone = 2'b00;
    localparam memCtrl_t MemWr   = 2'b01;
    localparam memCtrl_t MemRd   = 2'b10;

    // One table row, execute inputs plus the check made two edges later
    typedef struct packed {
        wbCtrl_t    wb;
        memCtrl_t   mc;
        logic       jl;
        word_t      ia;
        word_t      alu;
        word_t      rb;
        regAddr_t   dst;
        logic       stop;
        logic       dbg;
        logic [1:0] kind;
        word_t      idx;
        word_t      exp;
    } stimRow_t;

    logic     clk;
    logic     rst;
    wbCtrl_t  wbCtrlIn;
    memCtrl_t memCtrlIn;
    logic     jumpLink;
    word_t    instrAddr;
    word_t    aluResult;
    word_t    regB;
    regAddr_t destReg;
    logic     debugOn;
    word_t    debugAddr;
    logic     stopDebug;
    regAddr_t regReadAddr;
    word_t    memDebug;
    word_t    regReadData;

    stimRow_t rows[$];
    int       cycleLimit;
    int       cycleCount;
    int       errorCount;

    memWbPipe dut0 (
        .clk         (clk),
        .rst         (rst),
        .wbCtrlIn    (wbCtrlIn),
        .memCtrlIn   (memCtrlIn),
        .jumpLink    (jumpLink),
        .instrAddr   (instrAddr),
        .aluResult   (aluResult),
        .regB        (regB),
        .destReg     (destReg),
        .debugOn     (debugOn),
        .debugAddr   (debugAddr),
        .stopDebug   (stopDebug),
        .regReadAddr (regReadAddr),
        .memDebug    (memDebug),
        .regReadData (regReadData)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model of byte lanes
    //////////////////////////////////////////////////

    // Write-back control word from its fields
    function automatic wbCtrl_t makeWb(logic regWrite, logic memToReg, accSize_t size,
                                       logic uns);
        return {uns, size, memToReg, regWrite};
    endfunction

    // Little-endian lane update for a sized store
    function automatic word_t laneStore(word_t oldWord, word_t data, accSize_t size,
                                        logic [1:0] off);
        word_t result;
        int    bytePos;
        int    halfPos;
        result  = oldWord;
        bytePos = int'(off);
        halfPos = int'(off[1]);
        case (size)
            2'd0:    result[8*bytePos +: 8] = data[7:0];
            2'd1:    result[16*halfPos +: 16] = data[15:0];
            default: result = data;
        endcase
        return result;
    endfunction

    // Lane pick and extension for a sized load
    function automatic word_t laneLoad(word_t w, accSize_t size, logic [1:0] off, logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       result;
        b = w[8*int'(off) +: 8];
        h = w[16*int'(off[1]) +: 16];
        case (size)
            2'd0:    result = uns ? {24'h0, b} : {{24{b[7]}}, b};
            2'd1:    result = uns ? {16'h0, h} : {{16{h[15]}}, h};
            default: result = w;
        endcase
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Table construction
    //////////////////////////////////////////////////

    function automatic void addRow(wbCtrl_t wb, memCtrl_t mc, logic jl, word_t ia,
                                   word_t alu, word_t rb, regAddr_t dst, logic stop,
                                   logic dbg, logic [1:0] kind, word_t idx, word_t exp);
        rows.push_back({wb, mc, jl, ia, alu, rb, dst, stop, dbg, kind, idx, exp});
    endfunction

    // Bubble row that only carries a check
    function automatic void addCheck(logic stop, logic dbg, logic [1:0] kind, word_t idx,
                                     word_t exp);
        addRow('0, MemNone, 1'b0, '0, '0, '0, '0, stop, dbg, kind, idx, exp);
    endfunction

    task automatic buildRows();
        word_t      baseWord;
        word_t      data;
        word_t      addr;
        word_t      rnd;
        word_t      stored;
        word_t      firstStored;
        logic [1:0] off;
        accSize_t   size;
        firstStored = '0;

        // Word store, word load into r3
        addRow(makeWb(1'b0, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, 32'h100, 32'hCAFEF00D,
               5'd0, 1'b0, 1'b0, ChkMem, 32'h100, 32'hCAFEF00D);
        addRow(makeWb(1'b1, 1'b1, 2'd2, 1'b0), MemRd, 1'b0, '0, 32'h100, '0,
               5'd3, 1'b0, 1'b0, ChkReg, 32'd3, 32'hCAFEF00D);

        // ALU write-back, r0 write, regWrite low
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemNone, 1'b0, '0, 32'h12345678, '0,
               5'd5, 1'b0, 1'b0, ChkReg, 32'd5, 32'h12345678);
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemNone, 1'b0, '0, 32'hFFFFFFFF, '0,
               5'd0, 1'b0, 1'b0, ChkReg, 32'd0, 32'h0);
        addRow(makeWb(1'b0, 1'b0, 2'd2, 1'b0), MemNone, 1'b0, '0, 32'hDEADBEEF, '0,
               5'd5, 1'b0, 1'b0, ChkReg, 32'd5, 32'h12345678);

        // Jump-and-link lands in the link register, not in r9
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemNone, 1'b1, 32'h00400020, 32'h55, '0,
               5'd9, 1'b0, 1'b0, ChkReg, `LINK_REG, 32'h00400020);
        addCheck(1'b0, 1'b0, ChkReg, 32'd9, 32'h0);

        // Random sub-word stores and loads, byte and half alternating
        for (int n = 0; n < 6; n++)
        begin
            baseWord = $urandom;
            data     = $urandom;
            rnd      = $urandom;
            off      = rnd[1:0];
            size     = accSize_t'(n % 2);
            addr     = 32'h200 + word_t'(4 * n);
            stored   = laneStore(baseWord, data, size, off);
            if (n == 0)
            begin
                firstStored = stored;
            end
            addRow(makeWb(1'b0, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, addr, baseWord,
                   5'd0, 1'b0, 1'b0, ChkNone, '0, '0);
            addRow(makeWb(1'b0, 1'b0, size, 1'b0), MemWr, 1'b0, '0, addr + word_t'(off),
                   data, 5'd0, 1'b0, 1'b0, ChkMem, addr, stored);
            addRow(makeWb(1'b1, 1'b1, size, 1'b0), MemRd, 1'b0, '0, addr + word_t'(off), '0,
                   regAddr_t'(10 + n), 1'b0, 1'b0, ChkReg, word_t'(10 + n),
                   laneLoad(stored, size, off, 1'b0));
            addRow(makeWb(1'b1, 1'b1, size, 1'b1), MemRd, 1'b0, '0, addr + word_t'(off), '0,
                   regAddr_t'(20 + n), 1'b0, 1'b0, ChkReg, word_t'(20 + n),
                   laneLoad(stored, size, off, 1'b1));
        end

        // Freeze with a store and an r8 write presented
        // Upstream keeps them at the inputs until release, then they land once
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemNone, 1'b0, '0, 32'h0BADCAFE, '0,
               5'd7, 1'b0, 1'b0, ChkReg, 32'd7, 32'h0BADCAFE);
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, 32'h300, 32'h11111111,
               5'd8, 1'b1, 1'b0, ChkMem, 32'h300, 32'h0);
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, 32'h300, 32'h11111111,
               5'd8, 1'b1, 1'b0, ChkReg, 32'd8, 32'h0);
        addRow(makeWb(1'b1, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, 32'h300, 32'h11111111,
               5'd8, 1'b0, 1'b0, ChkMem, 32'h300, 32'h11111111);
        addCheck(1'b0, 1'b0, ChkReg, 32'd8, 32'h300);
        addRow(makeWb(1'b0, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, 32'h300, 32'h22222222,
               5'd0, 1'b0, 1'b0, ChkMem, 32'h300, 32'h22222222);

        // Debug mode, suppressed store and reads anywhere
        addRow(makeWb(1'b0, 1'b0, 2'd2, 1'b0), MemWr, 1'b0, '0, 32'h100, 32'h33333333,
               5'd0, 1'b0, 1'b1, ChkMem, 32'h100, 32'hCAFEF00D);
        addCheck(1'b0, 1'b1, ChkMem, 32'h300, 32'h22222222);
        addCheck(1'b0, 1'b1, ChkMem, 32'h200, firstStored);
        addCheck(1'b0, 1'b1, ChkMem, 32'h3FC, 32'h0);
        addRow(makeWb(1'b1, 1'b1, 2'd2, 1'b0), MemRd, 1'b0, '0, 32'h100, '0,
               5'd4, 1'b0, 1'b0, ChkReg, 32'd4, 32'hCAFEF00D);
    endtask

    //////////////////////////////////////////////////
    // Drive and compare
    //////////////////////////////////////////////////

    task automatic applyRow(stimRow_t r);
        wbCtrlIn  = r.wb;
        memCtrlIn = r.mc;
        jumpLink  = r.jl;
        instrAddr = r.ia;
        aluResult = r.alu;
        regB      = r.rb;
        destReg   = r.dst;
        stopDebug = r.stop;
        debugOn   = r.dbg;
    endtask

    task automatic checkReg(regAddr_t idx, word_t exp);
        regReadAddr = idx;
        #1;
        if (regReadData !== exp)
        begin
            errorCount++;
            $display("[ERROR] %0t regReadData (r%0d) got %h expected %h",
                     $time, idx, regReadData, exp);
            $display("Something failed");
            $fatal(1, "Register compare mismatch");
        end
    endtask

    task automatic checkMem(word_t addr, word_t exp);
        debugAddr = addr;
        #1;
        if (memDebug !== exp)
        begin
            errorCount++;
            $display("[ERROR] %0t memDebug (addr %h) got %h expected %h",
                     $time, addr, memDebug, exp);
            $display("Something failed");
            $fatal(1, "Memory compare mismatch");
        end
    endtask

    task automatic runCheck(stimRow_t r);
        case (r.kind)
            ChkReg:  checkReg(regAddr_t'(r.idx[4:0]), r.exp);
            ChkMem:  checkMem(r.idx, r.exp);
            default: ;
        endcase
    endtask

    // Watchdog, limit known once the table exists
    initial
    begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: table not finished after %0d cycles", cycleCount);
        $display("Something failed");
        $fatal(1, "Simulation timed out");
    end

    initial
    begin
        wbCtrlIn    = '0;
        memCtrlIn   = '0;
        jumpLink    = 1'b0;
        instrAddr   = '0;
        aluResult   = '0;
        regB        = '0;
        destReg     = '0;
        debugOn     = 1'b0;
        debugAddr   = '0;
        stopDebug   = 1'b0;
        regReadAddr = '0;
        rst         = 1'b1;
        errorCount  = 0;
        cycleLimit  = 0;
        void'($urandom(32'hdf589cbe));
        buildRows();
        cycleLimit = rows.size() * 4 + 20;

        // 4 cycles of reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Row i issued while row i-2 is checked, two idle rows drain the pipe
        for (int i = 0; i < rows.size() + 2; i++)
        begin
            @(negedge clk);
            if (i < rows.size())
            begin
                applyRow(rows[i]);
            end
            else
            begin
                applyRow('0);
            end
            if (i >= 2)
            begin
                runCheck(rows[i-2]);
            end
        end

        if (errorCount == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            $display("Something failed");
            $fatal(1, "Checks failed");
        end
    end

endmodule

//--- memWbPipe.f
+incdir+hdl
hdl/mipsMemPkg.sv
hdl/dataMemory.sv
hdl/memoryAccess.sv
hdl/writeBackRegFile.sv
hdl/memWbPipe.sv
verif/memWbPipe_props.sv
verif/memWbPipe_tb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the memory/write-back testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

rm -rf "$BUILD" "$LOG"

# RTL, bound assertions and testbench
verilator --binary --timing --assert -j 0 \
    -f memWbPipe.f \
    --top-module memWbPipe_tb \
    --Mdir "$BUILD" \
    -o memWbPipe_sim

# Exit status of the pipe is the one of tee, the log decides
"./$BUILD/memWbPipe_sim" 2>&1 | tee "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
    echo "RESULT: FAIL (run ended early)"
    exit 1
fi
echo "RESULT: PASS"
